/* hdl/vga_pkg.sv */
package vga_pkg;

    // Pixel index and RGB565 channel widths
    localparam int PIX_IDX_W = 4;
    localparam int RED_W     = 5;
    localparam int GREEN_W   = 6;
    localparam int BLUE_W    = 5;

    typedef struct packed {
        logic [RED_W-1:0]   r;
        logic [GREEN_W-1:0] g;
        logic [BLUE_W-1:0]  b;
    } rgb565_t;

    // Fixed 16-entry palette, index 8 is the dim grey exception
    function automatic rgb565_t palette_color(input logic [PIX_IDX_W-1:0] idx);
        rgb565_t            c;
        logic [RED_W-1:0]   r_lvl;
        logic [GREEN_W-1:0] g_lvl;
        logic [BLUE_W-1:0]  b_lvl;
        c     = '0;
        r_lvl = idx[3] ? 5'd31 : 5'd15;
        g_lvl = idx[3] ? 6'd63 : 6'd31;
        b_lvl = idx[3] ? 5'd31 : 5'd15;
        if (idx == 4'h8) begin
            c.r = 5'd7;
            c.g = 6'd15;
            c.b = 5'd7;
        end else begin
            // Bit 2 red, bit 1 green, bit 0 blue
            if (idx[2]) begin
                c.r = r_lvl;
            end
            if (idx[1]) begin
                c.g = g_lvl;
            end
            if (idx[0]) begin
                c.b = b_lvl;
            end
        end
        return c;
    endfunction

endpackage

/* hdl/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33,
    parameter int CLK_DIV  = 4
) (
    input  logic clk,
    input  logic arst_n,
    output logic pix_tick,
    output logic raw_de,
    output logic raw_hs,
    output logic raw_vs,
    output logic frame_start
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int X_W     = $clog2(H_TOTAL);
    localparam int Y_W     = $clog2(V_TOTAL);
    localparam int DIV_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
    localparam logic [X_W-1:0]   X_LAST   = X_W'(H_TOTAL - 1);
    localparam logic [Y_W-1:0]   Y_LAST   = Y_W'(V_TOTAL - 1);

    // Sync windows sit right after the front porch
    localparam logic [X_W-1:0] HS_START = X_W'(H_ACTIVE + H_FP);
    localparam logic [X_W-1:0] HS_END   = X_W'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [Y_W-1:0] VS_START = Y_W'(V_ACTIVE + V_FP);
    localparam logic [Y_W-1:0] VS_END   = Y_W'(V_ACTIVE + V_FP + V_SYNC);

    logic [DIV_W-1:0] div_cnt;
    logic [X_W-1:0]   x;
    logic [Y_W-1:0]   y;
    logic             line_end;

    // Pixel tick divider
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            pix_tick <= 1'b0;
        end else begin
            pix_tick <= (div_cnt == DIV_LAST);
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign line_end = (x == X_LAST);

    // Raster counters, one step per tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
            y <= '0;
        end else if (pix_tick) begin
            if (line_end) begin
                x <= '0;
                y <= (y == Y_LAST) ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    assign raw_de      = (x < X_W'(H_ACTIVE)) && (y < Y_W'(V_ACTIVE));
    assign raw_hs      = (x >= HS_START) && (x < HS_END);
    assign raw_vs      = (y >= VS_START) && (y < VS_END);
    assign frame_start = pix_tick && (x == '0) && (y == '0);

    // Horizontal sync must stay clear of the visible area
    hs_outside_active: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(raw_hs && raw_de)
    );

endmodule

/* hdl/pixel_addr_gen.sv */
`timescale 1ns/1ps

module pixel_addr_gen #(
    parameter int ADDR_W = 19,
    parameter int DEPTH  = 307200
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pix_tick,
    input  logic              raw_de,
    input  logic              frame_start,
    output logic [ADDR_W-1:0] rd_addr
);

    // One extra bit so the count can reach DEPTH after the last pixel
    logic [ADDR_W:0] addr_cnt;
    logic [ADDR_W:0] addr_base;

    // Frame start forces address 0 on the tick at x=0, y=0
    assign addr_base = frame_start ? '0 : addr_cnt;
    assign rd_addr   = addr_base[ADDR_W-1:0];

    // Running raster index instead of x + y * width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_cnt <= '0;
        end else if (pix_tick) begin
            if (raw_de) begin
                addr_cnt <= addr_base + 1'b1;
            end else begin
                addr_cnt <= addr_base;
            end
        end
    end

    addr_in_frame: assert property (
        @(posedge clk) disable iff (!arst_n)
        addr_cnt <= (ADDR_W + 1)'(DEPTH)
    );

endmodule

/* hdl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram import vga_pkg::*; #(
    parameter int ADDR_W = 19,
    parameter int DEPTH  = 307200
) (
    input  logic                 clk,
    input  logic                 wr_en,
    input  logic [ADDR_W-1:0]    wr_addr,
    input  logic [PIX_IDX_W-1:0] wr_data,
    input  logic                 pix_tick,
    input  logic [ADDR_W-1:0]    rd_addr,
    output logic [PIX_IDX_W-1:0] pix_idx
);

    logic [PIX_IDX_W-1:0] mem [DEPTH];

    // Image load port at full clk rate
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side returns old data on a same-address collision
    always_ff @(posedge clk) begin
        if (pix_tick) begin
            pix_idx <= mem[rd_addr];
        end
    end

    wr_addr_in_range: assert property (
        @(posedge clk)
        wr_en |-> ({1'b0, wr_addr} < (ADDR_W + 1)'(DEPTH))
    );

endmodule

/* hdl/palette_lut.sv */
`timescale 1ns/1ps

module palette_lut import vga_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pix_tick,
    input  logic [PIX_IDX_W-1:0] pix_idx,
    output rgb565_t              color
);

    // One tick of lookup latency, black out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color <= '0;
        end else if (pix_tick) begin
            color <= palette_color(pix_idx);
        end
    end

endmodule

/* hdl/video_output.sv */
`timescale 1ns/1ps

module video_output import vga_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pix_tick,
    input  logic               raw_de,
    input  logic               raw_hs,
    input  logic               raw_vs,
    input  rgb565_t            color,
    output logic [RED_W-1:0]   vga_red,
    output logic [GREEN_W-1:0] vga_green,
    output logic [BLUE_W-1:0]  vga_blue,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_de
);

    // Flag order is {vs, hs, de}
    logic [2:0] flags_d1;
    logic [2:0] flags_d2;

    // Two ticks to line up with frame_ram and palette_lut
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_d1 <= '0;
            flags_d2 <= '0;
        end else if (pix_tick) begin
            flags_d1 <= {raw_vs, raw_hs, raw_de};
            flags_d2 <= flags_d1;
        end
    end

    // Output register blanks colour outside the active area
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
            vga_hs    <= 1'b0;
            vga_vs    <= 1'b0;
            vga_de    <= 1'b0;
        end else if (pix_tick) begin
            vga_red   <= flags_d2[0] ? color.r : '0;
            vga_green <= flags_d2[0] ? color.g : '0;
            vga_blue  <= flags_d2[0] ? color.b : '0;
            vga_de    <= flags_d2[0];
            vga_hs    <= flags_d2[1];
            vga_vs    <= flags_d2[2];
        end
    end

endmodule

/* hdl/vga_display.sv */
`timescale 1ns/1ps

module vga_display import vga_pkg::*; #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33,
    parameter int CLK_DIV   = 4,
    localparam int NUM_PIX  = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W   = $clog2(NUM_PIX)
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wr_en,
    input  logic [ADDR_W-1:0]    wr_addr,
    input  logic [PIX_IDX_W-1:0] wr_data,
    output logic [RED_W-1:0]     vga_red,
    output logic [GREEN_W-1:0]   vga_green,
    output logic [BLUE_W-1:0]    vga_blue,
    output logic                 vga_hs,
    output logic                 vga_vs,
    output logic                 vga_de
);

    logic                 pix_tick;
    logic                 raw_de;
    logic                 raw_hs;
    logic                 raw_vs;
    logic                 frame_start;
    logic [ADDR_W-1:0]    rd_addr;
    logic [PIX_IDX_W-1:0] pix_idx;
    rgb565_t              color;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .CLK_DIV  (CLK_DIV)
    ) video_timing_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix_tick    (pix_tick),
        .raw_de      (raw_de),
        .raw_hs      (raw_hs),
        .raw_vs      (raw_vs),
        .frame_start (frame_start)
    );

    pixel_addr_gen #(
        .ADDR_W (ADDR_W),
        .DEPTH  (NUM_PIX)
    ) pixel_addr_gen_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix_tick    (pix_tick),
        .raw_de      (raw_de),
        .frame_start (frame_start),
        .rd_addr     (rd_addr)
    );

    frame_ram #(
        .ADDR_W (ADDR_W),
        .DEPTH  (NUM_PIX)
    ) frame_ram_inst (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .pix_tick (pix_tick),
        .rd_addr  (rd_addr),
        .pix_idx  (pix_idx)
    );

    palette_lut palette_lut_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .pix_tick (pix_tick),
        .pix_idx  (pix_idx),
        .color    (color)
    );

    video_output video_output_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_tick  (pix_tick),
        .raw_de    (raw_de),
        .raw_hs    (raw_hs),
        .raw_vs    (raw_vs),
        .color     (color),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_de    (vga_de)
    );

endmodule

/* test/vga_display_tb.sv */
`timescale 1ns/1ps

module vga_display_tb;

    localparam int H_ACTIVE = 16;
    localparam int H_FP = 2;
    localparam int H_SYNC = 3;
    localparam int H_BP = 3;
    localparam int V_ACTIVE = 8;
    localparam int V_FP = 1;
    localparam int V_SYNC = 2;
    localparam int V_BP = 1;
    localparam int CLK_DIV = 2;
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_TICKS = H_TOTAL * V_TOTAL;
    localparam int NUM_PIX = H_ACTIVE * V_ACTIVE;
    localparam int ADDR_W = $clog2(NUM_PIX);
    localparam int IDX_W = 4;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG_NS = 4 * FRAME_TICKS * CLK_DIV * CLK_PERIOD + 2000;

    localparam int T_RESET = 0;
    localparam int T_HSYNC = 1;
    localparam int T_VSYNC = 2;
    localparam int T_ACTIVE = 3;
    localparam int T_IMAGE = 4;
    localparam int T_REWRITE = 5;
    localparam int NUM_TESTS = 6;

    logic clk;
    logic arst_n;
    logic wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [IDX_W-1:0] wr_data;
    logic [4:0] vga_red;
    logic [5:0] vga_green;
    logic [4:0] vga_blue;
    logic vga_hs;
    logic vga_vs;
    logic vga_de;

    logic [IDX_W-1:0] img [NUM_PIX];
    logic [15:0] lfsr_state = 16'd5;
    int test_errs [NUM_TESTS];
    int total_errs = 0;
    int failed_tests = 0;

    // Monitor state where output tick n shows raster index n - 3
    logic tick_prev = 1'b0;
    int tick_n = 0;
    int pos;
    int x;
    int y;
    int out_frame = 0;
    int pix_n = 0;
    int line_de = 0;
    int act_lines = 0;
    int rgb_test;
    logic exp_de;
    logic exp_hs;
    logic exp_vs;
    logic [15:0] exp_rgb;

    vga_display #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .CLK_DIV  (CLK_DIV)
    ) vga_display_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_de    (vga_de)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // Bit 2 red, bit 1 green, bit 0 blue and bit 3 full scale
    function automatic logic [15:0] ref_palette(input logic [IDX_W-1:0] idx);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        if (idx == 4'd8) begin
            return {5'd7, 6'd15, 5'd7};
        end
        r = !idx[2] ? 5'd0 : (idx[3] ? 5'd31 : 5'd15);
        g = !idx[1] ? 6'd0 : (idx[3] ? 6'd63 : 6'd31);
        b = !idx[0] ? 5'd0 : (idx[3] ? 5'd31 : 5'd15);
        return {r, g, b};
    endfunction

    task automatic compare_value(input int test_id, input string name,
            input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at tick %0d", name, got, exp, tick_n);
            test_errs[test_id] = test_errs[test_id] + 1;
        end
    endtask

    // Colour is skipped when rgb_t is negative
    task automatic check_outputs(input int sync_t, input int de_t, input int rgb_t,
            input logic [15:0] rgb, input logic hs, input logic vs, input logic de);
        compare_value(sync_t == T_RESET ? T_RESET : T_HSYNC, "vga_hs", 32'(vga_hs), 32'(hs));
        compare_value(sync_t == T_RESET ? T_RESET : T_VSYNC, "vga_vs", 32'(vga_vs), 32'(vs));
        compare_value(de_t, "vga_de", 32'(vga_de), 32'(de));
        if (rgb_t >= 0) begin
            compare_value(rgb_t, "vga_red", 32'(vga_red), 32'(rgb[15:11]));
            compare_value(rgb_t, "vga_green", 32'(vga_green), 32'(rgb[10:5]));
            compare_value(rgb_t, "vga_blue", 32'(vga_blue), 32'(rgb[4:0]));
        end
    endtask

    // Four LFSR bits per pixel and one write per clk
    task automatic load_image();
        logic [IDX_W-1:0] idx;
        for (int a = 0; a < NUM_PIX; a++) begin
            idx = '0;
            for (int b = 0; b < IDX_W; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                idx = {idx[IDX_W-2:0], lfsr_state[0]};
            end
            img[a] = idx;
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= ADDR_W'(a);
            wr_data <= idx;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("test %-12s %s, %0d errors", name,
                 test_errs[test_id] == 0 ? "ok" : "FAILED", test_errs[test_id]);
        total_errs = total_errs + test_errs[test_id];
        if (test_errs[test_id] != 0) begin
            failed_tests = failed_tests + 1;
        end
    endtask

    // Outputs are sampled on the falling edge after each tick
    always @(negedge clk) begin
        if (tick_prev) begin
            tick_n = tick_n + 1;
            if (tick_n < 3) begin
                check_outputs(T_RESET, T_RESET, T_RESET, 16'h0, 1'b0, 1'b0, 1'b0);
            end else begin
                pos = tick_n - 3;
                x = pos % H_TOTAL;
                y = (pos / H_TOTAL) % V_TOTAL;
                out_frame = pos / FRAME_TICKS;
                if (x == 0 && y == 0) begin
                    pix_n = 0;
                end
                exp_de = (x < H_ACTIVE) && (y < V_ACTIVE);
                exp_hs = (x >= H_ACTIVE + H_FP) && (x < H_ACTIVE + H_FP + H_SYNC);
                exp_vs = (y >= V_ACTIVE + V_FP) && (y < V_ACTIVE + V_FP + V_SYNC);
                exp_rgb = 16'h0;
                rgb_test = T_ACTIVE;
                if (exp_de) begin
                    exp_rgb = ref_palette(img[pix_n % NUM_PIX]);
                    // Frame 0 scans while the first image is still loading
                    rgb_test = (out_frame == 0) ? -1 : (out_frame == 1 ? T_IMAGE : T_REWRITE);
                end
                check_outputs(T_HSYNC, T_ACTIVE, rgb_test, exp_rgb, exp_hs, exp_vs, exp_de);
                if (exp_de) begin
                    pix_n = pix_n + 1;
                end
                if (vga_de) begin
                    line_de = line_de + 1;
                end
                if (x == H_TOTAL - 1) begin
                    compare_value(T_ACTIVE, "vga_de per line", 32'(line_de),
                                  y < V_ACTIVE ? 32'(H_ACTIVE) : 32'd0);
                    if (line_de > 0) begin
                        act_lines = act_lines + 1;
                    end
                    line_de = 0;
                end
                if (x == H_TOTAL - 1 && y == V_TOTAL - 1) begin
                    compare_value(T_ACTIVE, "vga_de lines", 32'(act_lines), 32'(V_ACTIVE));
                    act_lines = 0;
                end
            end
        end
        tick_prev = vga_display_inst.pix_tick;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the last frame was checked");
        $display("sim failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errs[i] = 0;
        end
        arst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_outputs(T_RESET, T_RESET, T_RESET, 16'h0, 1'b0, 1'b0, 1'b0);
        @(posedge clk);
        arst_n <= 1'b1;
        load_image();
        wait (tick_n >= 3);
        report_test(T_RESET, "reset");
        wait (out_frame == 1);
        // Rewrite in vertical blanking once frame 1 active output is over
        @(posedge vga_vs);
        load_image();
        report_test(T_IMAGE, "image");
        wait (out_frame == 3);
        report_test(T_HSYNC, "hsync");
        report_test(T_VSYNC, "vsync");
        report_test(T_ACTIVE, "active area");
        report_test(T_REWRITE, "rewrite");
        $display("%0d tests, %0d failed, %0d check errors", NUM_TESTS, failed_tests, total_errs);
        if (total_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* vga_display.f */
hdl/vga_pkg.sv
hdl/video_timing.sv
hdl/pixel_addr_gen.sv
hdl/frame_ram.sv
hdl/palette_lut.sv
hdl/video_output.sv
hdl/vga_display.sv
test/vga_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the VGA display testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -j 0 \
        -f vga_display.f --top-module vga_display_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vvga_display_tb); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'sim passed'; then
    exit 0
fi
exit 1
